// File: Makefile
# Verilator build and run for the UMI to TileLink-UH bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_umi2tl_np
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/umi2tl_a_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TileLink A-channel formatter. Byte counts other than 1, 2, 4 or 8 are
// not supported and are sent as a full beat. Only the low TL_DW bits of
// the UMI data are used. Unknown UMI opcodes issue a Get.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module umi2tl_a_channel (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 accept,
    input  umi2tl_pkg::umi_req_t udev_req,
    output logic [2:0]           lane_shift,
    output logic                 tl_a_valid,
    output umi2tl_pkg::tl_a_t    tl_a,
    input  logic                 tl_a_ready
);

    logic [15:0]                          req_bytes;
    logic [2:0]                           beat_size;
    logic [2:0]                           align;
    logic [umi2tl_pkg::TL_MASKW-1:0]      base_mask;
    logic [2:0]                           beat_opcode;
    logic [2:0]                           beat_param;
    logic [umi2tl_pkg::TL_DW-1:0]         beat_data;

    // Atomics move one element, reads and writes len+1 of them
    always_comb begin
        if (udev_req.cmd.opcode == umi2tl_pkg::UMI_REQ_ATOMIC) begin
            req_bytes = 16'd1 << udev_req.cmd.size;
        end else begin
            req_bytes = (16'd1 << udev_req.cmd.size) *
                        (16'(udev_req.cmd.len_atype.len) + 16'd1);
        end
    end

    always_comb begin
        case (req_bytes)
            16'd1: begin
                beat_size = 3'd0;
                base_mask = 8'h01;
                align     = 3'b111;
            end
            16'd2: begin
                beat_size = 3'd1;
                base_mask = 8'h03;
                align     = 3'b110;
            end
            16'd4: begin
                beat_size = 3'd2;
                base_mask = 8'h0f;
                align     = 3'b100;
            end
            default: begin
                beat_size = 3'($clog2(umi2tl_pkg::TL_BYTES));
                base_mask = 8'hff;
                align     = 3'b000;
            end
        endcase
    end

    assign lane_shift = udev_req.dstaddr[2:0] & align;
    assign beat_data  = udev_req.data[umi2tl_pkg::TL_DW-1:0] << {lane_shift, 3'b000};

    always_comb begin
        beat_opcode = umi2tl_pkg::TL_GET;
        beat_param  = 3'd0;
        case (udev_req.cmd.opcode)
            umi2tl_pkg::UMI_REQ_WRITE: beat_opcode = umi2tl_pkg::TL_PUT_FULL;
            umi2tl_pkg::UMI_REQ_ATOMIC: begin
                beat_opcode = umi2tl_pkg::TL_ARITH;
                case (udev_req.cmd.len_atype.atype)
                    umi2tl_pkg::UMI_ATOMIC_ADD:  beat_param = umi2tl_pkg::TL_PA_ADD;
                    umi2tl_pkg::UMI_ATOMIC_MAX:  beat_param = umi2tl_pkg::TL_PA_MAX;
                    umi2tl_pkg::UMI_ATOMIC_MIN:  beat_param = umi2tl_pkg::TL_PA_MIN;
                    umi2tl_pkg::UMI_ATOMIC_MAXU: beat_param = umi2tl_pkg::TL_PA_MAXU;
                    umi2tl_pkg::UMI_ATOMIC_MINU: beat_param = umi2tl_pkg::TL_PA_MINU;
                    umi2tl_pkg::UMI_ATOMIC_AND: begin
                        beat_opcode = umi2tl_pkg::TL_LOGICAL;
                        beat_param  = umi2tl_pkg::TL_PL_AND;
                    end
                    umi2tl_pkg::UMI_ATOMIC_OR: begin
                        beat_opcode = umi2tl_pkg::TL_LOGICAL;
                        beat_param  = umi2tl_pkg::TL_PL_OR;
                    end
                    umi2tl_pkg::UMI_ATOMIC_XOR: begin
                        beat_opcode = umi2tl_pkg::TL_LOGICAL;
                        beat_param  = umi2tl_pkg::TL_PL_XOR;
                    end
                    default: begin
                        beat_opcode = umi2tl_pkg::TL_LOGICAL;
                        beat_param  = umi2tl_pkg::TL_PL_SWAP;
                    end
                endcase
            end
            default: beat_opcode = umi2tl_pkg::TL_GET;
        endcase
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            tl_a_valid <= 1'b0;
        end else if (accept) begin
            tl_a_valid <= 1'b1;
        end else if (tl_a_ready) begin
            tl_a_valid <= 1'b0;
        end
    end

    // Beat held until the slave takes it
    always_ff @(posedge clk) begin
        if (accept) begin
            tl_a.opcode  <= beat_opcode;
            tl_a.param   <= beat_param;
            tl_a.size    <= beat_size;
            tl_a.address <= {udev_req.dstaddr[umi2tl_pkg::TL_AW-1:3], 3'b000};
            tl_a.mask    <= base_mask << lane_shift;
            tl_a.data    <= beat_data;
        end
    end

endmodule

// File: source/umi2tl_d_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TileLink D-channel to UMI response. Any D opcode other than AccessAck
// is answered as a read response. D param, sink, denied and corrupt are
// not looked at. resp_done is registered, one cycle after the transfer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module umi2tl_d_channel (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 guard_ok,
    input  umi2tl_pkg::umi_req_t saved_req,
    input  logic [2:0]           saved_shift,
    input  logic                 tl_d_valid,
    input  umi2tl_pkg::tl_d_t    tl_d,
    output logic                 tl_d_ready,
    output logic                 udev_resp_valid,
    output umi2tl_pkg::umi_req_t udev_resp,
    input  logic                 udev_resp_ready,
    output logic                 resp_done
);

    logic d_take;
    logic resp_take;

    assign tl_d_ready = guard_ok & (~udev_resp_valid | udev_resp_ready);
    assign d_take     = tl_d_valid & tl_d_ready;
    assign resp_take  = udev_resp_valid & udev_resp_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            udev_resp_valid <= 1'b0;
            resp_done       <= 1'b0;
        end else begin
            resp_done <= resp_take;
            if (d_take) begin
                udev_resp_valid <= 1'b1;
            end else if (resp_take) begin
                udev_resp_valid <= 1'b0;
            end
        end
    end

    // Addresses swap so the response returns to the requester
    always_ff @(posedge clk) begin
        if (d_take) begin
            udev_resp.cmd.rest      <= saved_req.cmd.rest;
            udev_resp.cmd.len_atype <= saved_req.cmd.len_atype;
            udev_resp.cmd.size      <= saved_req.cmd.size;
            if (tl_d.opcode == umi2tl_pkg::TL_ACCESS_ACK) begin
                udev_resp.cmd.opcode <= umi2tl_pkg::UMI_RESP_WRITE;
            end else begin
                udev_resp.cmd.opcode <= umi2tl_pkg::UMI_RESP_READ;
            end
            udev_resp.dstaddr <= saved_req.srcaddr;
            udev_resp.srcaddr <= saved_req.dstaddr;
            // Bring the lanes back down to byte zero
            udev_resp.data <= umi2tl_pkg::UMI_DW'(tl_d.data >> {saved_shift, 3'b000});
        end
    end

endmodule

// File: source/umi2tl_np.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UMI device port to TileLink-UH bridge, one transaction in flight.
// Requests must move a power of two bytes, at most one TileLink beat.
// Posted writes are not supported and must not be sent.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module umi2tl_np (
    input  logic                 clk,
    input  logic                 nreset,

    input  logic                 udev_req_valid,
    input  umi2tl_pkg::umi_req_t udev_req,
    output logic                 udev_req_ready,

    output logic                 udev_resp_valid,
    output umi2tl_pkg::umi_req_t udev_resp,
    input  logic                 udev_resp_ready,

    output logic                 tl_a_valid,
    output umi2tl_pkg::tl_a_t    tl_a,
    input  logic                 tl_a_ready,

    input  logic                 tl_d_valid,
    input  umi2tl_pkg::tl_d_t    tl_d,
    output logic                 tl_d_ready
);

    umi2tl_pkg::umi_req_t saved_req;
    logic [2:0]           lane_shift;
    logic [2:0]           saved_shift;
    logic                 guard_ok;
    logic                 resp_done;

    umi2tl_tracker umi2tl_tracker_inst (
        .clk            (clk),
        .nreset         (nreset),
        .udev_req_valid (udev_req_valid),
        .udev_req       (udev_req),
        .lane_shift     (lane_shift),
        .resp_done      (resp_done),
        .req_ready      (udev_req_ready),
        .guard_ok       (guard_ok),
        .saved_req      (saved_req),
        .saved_shift    (saved_shift)
    );

    umi2tl_a_channel umi2tl_a_channel_inst (
        .clk        (clk),
        .nreset     (nreset),
        .accept     (udev_req_valid & udev_req_ready),
        .udev_req   (udev_req),
        .lane_shift (lane_shift),
        .tl_a_valid (tl_a_valid),
        .tl_a       (tl_a),
        .tl_a_ready (tl_a_ready)
    );

    umi2tl_d_channel umi2tl_d_channel_inst (
        .clk             (clk),
        .nreset          (nreset),
        .guard_ok        (guard_ok),
        .saved_req       (saved_req),
        .saved_shift     (saved_shift),
        .tl_d_valid      (tl_d_valid),
        .tl_d            (tl_d),
        .tl_d_ready      (tl_d_ready),
        .udev_resp_valid (udev_resp_valid),
        .udev_resp       (udev_resp),
        .udev_resp_ready (udev_resp_ready),
        .resp_done       (resp_done)
    );

endmodule

// File: source/umi2tl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared codes, widths and payload types for the UMI to TileLink-UH bridge.
// A TileLink beat carries at most TL_BYTES bytes, so a UMI request must fit
// one beat. Atomic type codes follow the UMI specification order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package umi2tl_pkg;

    localparam int UMI_AW   = 64;
    localparam int UMI_DW   = 128;
    localparam int TL_DW    = 64;
    localparam int TL_AW    = 56;
    localparam int TL_BYTES = 8;
    localparam int TL_MASKW = 8;

    // UMI opcodes
    localparam logic [4:0] UMI_REQ_READ   = 5'd1;
    localparam logic [4:0] UMI_REQ_WRITE  = 5'd3;
    localparam logic [4:0] UMI_REQ_ATOMIC = 5'd9;
    localparam logic [4:0] UMI_RESP_READ  = 5'd2;
    localparam logic [4:0] UMI_RESP_WRITE = 5'd4;

    // UMI atomic types
    localparam logic [7:0] UMI_ATOMIC_ADD  = 8'd0;
    localparam logic [7:0] UMI_ATOMIC_AND  = 8'd1;
    localparam logic [7:0] UMI_ATOMIC_OR   = 8'd2;
    localparam logic [7:0] UMI_ATOMIC_XOR  = 8'd3;
    localparam logic [7:0] UMI_ATOMIC_MAX  = 8'd4;
    localparam logic [7:0] UMI_ATOMIC_MIN  = 8'd5;
    localparam logic [7:0] UMI_ATOMIC_MAXU = 8'd6;
    localparam logic [7:0] UMI_ATOMIC_MINU = 8'd7;
    localparam logic [7:0] UMI_ATOMIC_SWAP = 8'd8;

    // TileLink A and D opcodes
    localparam logic [2:0] TL_GET             = 3'd4;
    localparam logic [2:0] TL_PUT_FULL        = 3'd0;
    localparam logic [2:0] TL_ARITH           = 3'd2;
    localparam logic [2:0] TL_LOGICAL         = 3'd3;
    localparam logic [2:0] TL_ACCESS_ACK      = 3'd0;
    localparam logic [2:0] TL_ACCESS_ACK_DATA = 3'd1;

    // Atomic params
    localparam logic [2:0] TL_PA_MIN  = 3'd0;
    localparam logic [2:0] TL_PA_MAX  = 3'd1;
    localparam logic [2:0] TL_PA_MINU = 3'd2;
    localparam logic [2:0] TL_PA_MAXU = 3'd3;
    localparam logic [2:0] TL_PA_ADD  = 3'd4;
    localparam logic [2:0] TL_PL_XOR  = 3'd0;
    localparam logic [2:0] TL_PL_OR   = 3'd1;
    localparam logic [2:0] TL_PL_AND  = 3'd2;
    localparam logic [2:0] TL_PL_SWAP = 3'd3;

    // Length for reads and writes, atomic type for atomics
    typedef union packed {
        logic [7:0] len;
        logic [7:0] atype;
    } umi_len_atype_u;

    typedef struct packed {
        logic [15:0]    rest;
        umi_len_atype_u len_atype;
        logic [2:0]     size;
        logic [4:0]     opcode;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t            cmd;
        logic [UMI_AW-1:0]   dstaddr;
        logic [UMI_AW-1:0]   srcaddr;
        logic [UMI_DW-1:0]   data;
    } umi_req_t;

    typedef struct packed {
        logic [2:0]          opcode;
        logic [2:0]          param;
        logic [2:0]          size;
        logic [TL_AW-1:0]    address;
        logic [TL_MASKW-1:0] mask;
        logic [TL_DW-1:0]    data;
    } tl_a_t;

    typedef struct packed {
        logic [2:0]       opcode;
        logic [TL_DW-1:0] data;
    } tl_d_t;

endpackage

// File: source/umi2tl_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request tracker. Holds off all traffic for two cycles after reset and
// allows a single request in flight. The data field of saved_req is zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module umi2tl_tracker (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 udev_req_valid,
    input  umi2tl_pkg::umi_req_t udev_req,
    input  logic [2:0]           lane_shift,
    input  logic                 resp_done,
    output logic                 req_ready,
    output logic                 guard_ok,
    output umi2tl_pkg::umi_req_t saved_req,
    output logic [2:0]           saved_shift
);

    logic [1:0] guard_q;
    logic       in_flight;
    logic       done_q;
    logic       accept;

    assign guard_ok  = guard_q[1];
    assign req_ready = guard_ok & ~in_flight;
    assign accept    = udev_req_valid & req_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            guard_q   <= 2'b00;
            in_flight <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            guard_q <= {guard_q[0], 1'b1};
            done_q  <= resp_done;
            if (accept) begin
                in_flight <= 1'b1;
            end else if (done_q) begin
                in_flight <= 1'b0;
            end
        end
    end

    // Metadata for building the response
    always_ff @(posedge clk) begin
        if (accept) begin
            saved_req <= '{cmd:     udev_req.cmd,
                           dstaddr: udev_req.dstaddr,
                           srcaddr: udev_req.srcaddr,
                           data:    '0};
            saved_shift <= lane_shift;
        end
    end

endmodule

// File: verif/tb_umi2tl_np.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the UMI to TileLink-UH bridge. A 16-word TileLink slave
// model sits behind the DUT. Outputs are sampled on the falling edge,
// inputs change 10 ns after the rising edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_umi2tl_np;

    localparam int NTX = 59;

    logic clk;
    logic nreset;
    logic udev_req_valid;
    logic udev_req_ready;
    logic udev_resp_valid;
    logic udev_resp_ready;
    logic tl_a_valid;
    logic tl_a_ready;
    logic tl_d_valid;
    logic tl_d_ready;
    umi2tl_pkg::umi_req_t udev_req;
    umi2tl_pkg::umi_req_t udev_resp;
    umi2tl_pkg::tl_a_t    tl_a;
    umi2tl_pkg::tl_d_t    tl_d;

    umi2tl_pkg::tl_a_t exp_a_q[$];
    umi2tl_pkg::tl_d_t d_q[$];
    umi2tl_pkg::tl_a_t expect_beat;
    umi2tl_pkg::tl_d_t slave_resp;
    logic [3:0]        slave_idx;
    logic [63:0]       mem [16];
    integer            seed = 32'h9729;
    integer            stall_seed = 32'h9729 + 1;
    int                errors;
    int                a_count;
    int                resp_count;

    umi2tl_np umi2tl_np_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input bit ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("FAIL %0t: %s", $time, msg);
        end
    endtask

    function automatic logic [63:0] lane_bits(input int nbytes);
        return (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
    endfunction

    // New memory word after a TileLink A beat
    function automatic logic [63:0] apply_beat(input umi2tl_pkg::tl_a_t beat,
                                               input logic [63:0] old);
        int                 n;
        int                 s;
        logic [63:0]        wm;
        logic [63:0]        a;
        logic [63:0]        b;
        logic [63:0]        r;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        n = 1 << beat.size;
        s = 0;
        while (s < 7 && !beat.mask[s]) s++;
        wm = lane_bits(n);
        a  = (old >> (8 * s)) & wm;
        b  = (beat.data >> (8 * s)) & wm;
        sa = a << (64 - 8 * n);
        sb = b << (64 - 8 * n);
        r  = b;
        if (beat.opcode == umi2tl_pkg::TL_GET) return old;
        if (beat.opcode == umi2tl_pkg::TL_ARITH) begin
            case (beat.param)
                umi2tl_pkg::TL_PA_ADD:  r = a + b;
                umi2tl_pkg::TL_PA_MAX:  r = (sa > sb) ? a : b;
                umi2tl_pkg::TL_PA_MIN:  r = (sa < sb) ? a : b;
                umi2tl_pkg::TL_PA_MAXU: r = (a > b) ? a : b;
                default:                r = (a < b) ? a : b;
            endcase
        end else if (beat.opcode == umi2tl_pkg::TL_LOGICAL) begin
            case (beat.param)
                umi2tl_pkg::TL_PL_XOR: r = a ^ b;
                umi2tl_pkg::TL_PL_OR:  r = a | b;
                umi2tl_pkg::TL_PL_AND: r = a & b;
                default:               r = b;
            endcase
        end
        return (old & ~(wm << (8 * s))) | ((r & wm) << (8 * s));
    endfunction

    task automatic run_txn(input logic [4:0] op, input int nbytes, input logic [7:0] atype,
                           input logic [2:0] off, input logic [3:0] idx,
                           input logic [63:0] wdata, output logic [63:0] rdata);
        umi2tl_pkg::umi_req_t req;
        umi2tl_pkg::umi_req_t exp_r;
        umi2tl_pkg::tl_a_t    exp_a;
        int                   sh;
        req.cmd.rest   = 16'($random(seed));
        req.cmd.opcode = op;
        req.cmd.size   = 3'($clog2(nbytes));
        req.cmd.len_atype.len = 8'd0;
        if (op == umi2tl_pkg::UMI_REQ_ATOMIC) begin
            req.cmd.len_atype.atype = atype;
        end else if (nbytes > 1 && ($random(seed) & 1) != 0) begin
            // Same byte count as single bytes with a length
            req.cmd.size          = 3'd0;
            req.cmd.len_atype.len = 8'(nbytes - 1);
        end
        req.dstaddr      = {$random(seed), $random(seed)};
        req.dstaddr[6:0] = {idx, off};
        req.srcaddr      = {$random(seed), $random(seed)};
        req.data         = {$random(seed), $random(seed), $random(seed), $random(seed)};
        req.data[63:0]   = wdata;
        sh = int'(off) & ~(nbytes - 1) & 7;

        exp_a.param  = 3'd0;
        exp_a.opcode = umi2tl_pkg::TL_GET;
        if (op == umi2tl_pkg::UMI_REQ_WRITE) exp_a.opcode = umi2tl_pkg::TL_PUT_FULL;
        if (op == umi2tl_pkg::UMI_REQ_ATOMIC) begin
            exp_a.opcode = umi2tl_pkg::TL_ARITH;
            case (atype)
                umi2tl_pkg::UMI_ATOMIC_ADD:  exp_a.param = umi2tl_pkg::TL_PA_ADD;
                umi2tl_pkg::UMI_ATOMIC_MAX:  exp_a.param = umi2tl_pkg::TL_PA_MAX;
                umi2tl_pkg::UMI_ATOMIC_MIN:  exp_a.param = umi2tl_pkg::TL_PA_MIN;
                umi2tl_pkg::UMI_ATOMIC_MAXU: exp_a.param = umi2tl_pkg::TL_PA_MAXU;
                umi2tl_pkg::UMI_ATOMIC_MINU: exp_a.param = umi2tl_pkg::TL_PA_MINU;
                default: exp_a.opcode = umi2tl_pkg::TL_LOGICAL;
            endcase
            if (atype == umi2tl_pkg::UMI_ATOMIC_AND) exp_a.param = umi2tl_pkg::TL_PL_AND;
            if (atype == umi2tl_pkg::UMI_ATOMIC_OR)  exp_a.param = umi2tl_pkg::TL_PL_OR;
            if (atype == umi2tl_pkg::UMI_ATOMIC_XOR) exp_a.param = umi2tl_pkg::TL_PL_XOR;
            if (atype == umi2tl_pkg::UMI_ATOMIC_SWAP) exp_a.param = umi2tl_pkg::TL_PL_SWAP;
        end
        exp_a.size    = 3'($clog2(nbytes));
        exp_a.address = {req.dstaddr[umi2tl_pkg::TL_AW-1:7], idx, 3'b000};
        exp_a.mask    = 8'((9'd1 << nbytes) - 9'd1) << sh;
        exp_a.data    = wdata << (8 * sh);

        exp_r             = req;
        exp_r.cmd.opcode  = (op == umi2tl_pkg::UMI_REQ_WRITE) ? umi2tl_pkg::UMI_RESP_WRITE
                                                               : umi2tl_pkg::UMI_RESP_READ;
        exp_r.dstaddr     = req.srcaddr;
        exp_r.srcaddr     = req.dstaddr;
        exp_r.data        = '0;
        if (op != umi2tl_pkg::UMI_REQ_WRITE) exp_r.data[63:0] = mem[idx] >> (8 * sh);
        exp_a_q.push_back(exp_a);

        @(posedge clk);
        #10;
        udev_req       = req;
        udev_req_valid = 1'b1;
        do @(negedge clk); while (!udev_req_ready);
        @(posedge clk);
        #10 udev_req_valid = 1'b0;
        do @(negedge clk); while (!(udev_resp_valid && udev_resp_ready));
        check(udev_resp == exp_r, $sformatf("response %h, expected %h", udev_resp, exp_r));
        rdata = udev_resp.data[63:0];
    endtask

    // Every response transfer, expected or not
    always @(negedge clk) begin
        if (nreset && udev_resp_valid && udev_resp_ready) begin
            resp_count++;
        end
    end

    // Slave model, A side
    always @(negedge clk) begin
        if (nreset && tl_a_valid && tl_a_ready) begin
            a_count++;
            if (exp_a_q.size() == 0) begin
                check(1'b0, "A beat seen with no request outstanding");
            end else begin
                expect_beat = exp_a_q.pop_front();
                check(tl_a == expect_beat, $sformatf("A beat %h, expected %h", tl_a, expect_beat));
            end
            slave_idx         = tl_a.address[6:3];
            slave_resp.opcode = (tl_a.opcode == umi2tl_pkg::TL_PUT_FULL) ?
                                umi2tl_pkg::TL_ACCESS_ACK : umi2tl_pkg::TL_ACCESS_ACK_DATA;
            slave_resp.data   = (tl_a.opcode == umi2tl_pkg::TL_PUT_FULL) ? '0 : mem[slave_idx];
            mem[slave_idx]    = apply_beat(tl_a, mem[slave_idx]);
            d_q.push_back(slave_resp);
        end
    end

    // Slave model, D side
    initial begin
        tl_d_valid = 1'b0;
        tl_d       = '0;
        forever begin
            @(posedge clk);
            if (d_q.size() != 0) begin
                repeat ($unsigned($random(stall_seed)) % 4) @(posedge clk);
                #10;
                tl_d       = d_q.pop_front();
                tl_d_valid = 1'b1;
                do @(negedge clk); while (!tl_d_ready);
                @(posedge clk);
                #10 tl_d_valid = 1'b0;
            end
        end
    end

    initial begin
        tl_a_ready      = 1'b0;
        udev_resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            tl_a_ready      = ($random(stall_seed) & 3) != 0;
            udev_resp_ready = ($random(stall_seed) & 3) != 0;
        end
    end

    initial begin
        repeat (NTX * 40 + 200) @(posedge clk);
        $display("Timeout: the transactions did not complete in the allowed time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [63:0] wdata;
        logic [63:0] rdata;
        logic [3:0]  idx;
        int          kind;
        nreset         = 1'b0;
        udev_req_valid = 1'b0;
        udev_req       = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = {8{4'(i), ~4'(i)}} ^ 64'h0123_4567_89ab_cdef;
        end
        repeat (3) @(posedge clk);
        #10 nreset = 1'b1;
        @(negedge clk);
        check(!udev_req_ready && !tl_d_ready && !tl_a_valid && !udev_resp_valid,
              "control outputs not low after reset");
        repeat (2) @(negedge clk);
        check(udev_req_ready && tl_d_ready, "ready outputs not high two edges after reset");

        // Write then read back at every aligned offset
        for (int n = 1; n <= 8; n = n * 2) begin
            for (int off = 0; off < 8; off = off + n) begin
                idx   = 4'($random(seed));
                wdata = {$random(seed), $random(seed)};
                run_txn(umi2tl_pkg::UMI_REQ_WRITE, n, 8'd0, 3'(off), idx, wdata, rdata);
                run_txn(umi2tl_pkg::UMI_REQ_READ, n, 8'd0, 3'(off), idx, 64'd0, rdata);
                check((rdata & lane_bits(n)) == (wdata & lane_bits(n)),
                      $sformatf("read back %h, wrote %h", rdata, wdata));
            end
        end
        for (int t = 0; t <= 8; t++) begin
            run_txn(umi2tl_pkg::UMI_REQ_ATOMIC, 1 << ($unsigned($random(seed)) % 4), 8'(t),
                    3'($random(seed)), 4'($random(seed)), {$random(seed), $random(seed)},
                    rdata);
        end
        repeat (20) begin
            kind = $unsigned($random(seed)) % 3;
            run_txn(kind == 0 ? umi2tl_pkg::UMI_REQ_READ :
                    kind == 1 ? umi2tl_pkg::UMI_REQ_WRITE : umi2tl_pkg::UMI_REQ_ATOMIC,
                    1 << ($unsigned($random(seed)) % 4), 8'($unsigned($random(seed)) % 9),
                    3'($random(seed)), 4'($random(seed)), {$random(seed), $random(seed)},
                    rdata);
        end
        repeat (5) @(posedge clk);
        check(a_count == NTX && resp_count == NTX, "A beat or response count is wrong");
        $display("Errors: %0d, A beats: %0d, responses: %0d, transactions: %0d",
                 errors, a_count, resp_count, NTX);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/umi2tl_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol properties bound into the bridge top level.
// Assumes one request in flight and the release timing of the tracker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module umi2tl_properties (
    input logic                 clk,
    input logic                 nreset,
    input logic                 udev_req_valid,
    input logic                 udev_req_ready,
    input logic                 udev_resp_valid,
    input umi2tl_pkg::umi_req_t udev_resp,
    input logic                 udev_resp_ready,
    input logic                 tl_a_valid,
    input umi2tl_pkg::tl_a_t    tl_a,
    input logic                 tl_a_ready,
    input logic                 tl_d_ready
);

    logic       busy;
    logic [1:0] tail;

    // Busy from request transfer until two edges after the response transfer
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            busy <= 1'b0;
            tail <= 2'd0;
        end else if (udev_req_valid && udev_req_ready) begin
            busy <= 1'b1;
        end else if (udev_resp_valid && udev_resp_ready) begin
            tail <= 2'd2;
        end else if (tail == 2'd2) begin
            tail <= 2'd1;
        end else if (tail == 2'd1) begin
            tail <= 2'd0;
            busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) !nreset |->
                     !tl_a_valid && !udev_resp_valid && !udev_req_ready && !tl_d_ready)
        else $error("Control outputs active during reset");

    assert property (@(posedge clk) $rose(nreset) |->
                     !udev_req_ready ##1 !udev_req_ready ##1 udev_req_ready)
        else $error("udev_req_ready did not rise on the second edge after reset");

    assert property (@(posedge clk) disable iff (!nreset)
                     tl_a_valid && !tl_a_ready |=> tl_a_valid && $stable(tl_a))
        else $error("A beat changed or dropped under back-pressure");

    assert property (@(posedge clk) disable iff (!nreset)
                     udev_resp_valid && !udev_resp_ready |=> udev_resp_valid && $stable(udev_resp))
        else $error("UMI response changed or dropped under back-pressure");

    assert property (@(posedge clk) disable iff (!nreset) busy |-> !udev_req_ready)
        else $error("udev_req_ready high while a transaction is in flight");

endmodule

bind umi2tl_np umi2tl_properties umi2tl_properties_inst (.*);

// File: vlog.f
source/umi2tl_pkg.sv
source/umi2tl_tracker.sv
source/umi2tl_a_channel.sv
source/umi2tl_d_channel.sv
source/umi2tl_np.sv
verif/umi2tl_properties.sv
verif/tb_umi2tl_np.sv
